// ==== msx_types_pkg.sv ====
/*
 * MSX glue types
 * Vector types for the menu status word, DDR3 addresses, image sizes
 * and the video fields handed to the scaler
 */
package msx_types_pkg;

   // Menu and host side
   typedef logic [63:0] status_t;
   typedef logic [15:0] menu_mask_t;
   typedef logic [15:0] io_index_t;
   typedef logic [7:0]  byte_t;

   // Mounted images
   typedef logic [63:0] img_size_t;
   typedef logic [5:0]  mount_vec_t;

   // Four 16-bit cartridge SRAM sizes side by side
   typedef logic [63:0] sram_sizes_t;

   // DDR3 byte address
   typedef logic [27:0] ddr3_addr_t;

   // Video fields
   typedef logic [11:0] aspect_t;
   typedef logic [11:0] pix_dim_t;
   typedef logic [11:0] crop_t;

endpackage

// ==== msx_cfg_pkg.sv ====
/*
 * MSX glue configuration
 * Menu status bit positions, menu mask positions, device and tape
 * constants, aspect and crop values and the SD activity period
 */
package msx_cfg_pkg;

   // ==================================================
   // Menu status word
   // ==================================================
   localparam int st_reset       = 0;
   localparam int st_aspect_lo   = 1;   // 2 bits
   localparam int st_scandbl_lo  = 3;   // 3 bits
   localparam int st_scale_lo    = 6;   // 3 bits
   localparam int st_tape_rewind = 9;
   localparam int st_detach      = 10;
   localparam int st_mount_reset = 12;
   localparam int st_reset_close = 21;

   // ==================================================
   // Menu hide mask
   // ==================================================
   localparam int mask_fdc    = 0;
   localparam int mask_slot_a = 1;
   localparam int mask_slot_b = 2;
   localparam int mask_ocm    = 3;
   localparam int mask_sram   = 6;
   localparam int mask_tape   = 7;

   // Devices and downloads
   localparam int sd_vhd_slot = 4;
   localparam int cas_index   = 5;   // low 6 bits of the index
   localparam int err_none    = 0;

   // Bus idle time before the LEDs go dark
   localparam int sd_activity_cycles = 1_000_000;

   // Original 4:3 aspect
   localparam int aspect_orig_x = 4;
   localparam int aspect_orig_y = 3;

   // 216p crop on a full HD output
   localparam int hdmi_full_w = 1920;
   localparam int hdmi_full_h = 1080;
   localparam int crop_216    = 216;

endpackage

// ==== core_control.sv ====
/*
 * Core control
 * Decodes core and hard reset, builds the menu hide mask and
 * forwards loader errors to the menu as an info message
 */
`timescale 1ns/1ps

module core_control (
   input  logic                      clock_bus,
   input  logic                      reset,
   input  msx_types_pkg::status_t     status,
   input  logic                      upload_reset,
   input  msx_types_pkg::mount_vec_t  img_mounted,
   input  logic                      fdc_enable,
   input  logic                      ocm_enable,
   input  logic                      rom_a_hide,
   input  logic                      rom_b_hide,
   input  msx_types_pkg::sram_sizes_t sram_sizes,
   input  logic                      tape_from_adc,
   input  msx_types_pkg::byte_t       error_code,
   output logic                      hard_reset,
   output logic                      core_reset,
   output msx_types_pkg::menu_mask_t  menu_mask,
   output logic                      info_req,
   output msx_types_pkg::byte_t       info
);
   import msx_types_pkg::*;
   import msx_cfg_pkg::*;

   logic mount_reset;

   // ==================================================
   // Reset decoding
   // ==================================================

   // Remount of the SD image restarts the machine when the FDC is present
   assign mount_reset = status[st_mount_reset] & img_mounted[sd_vhd_slot] & fdc_enable;

   assign hard_reset = reset | status[st_reset] | upload_reset;
   assign core_reset = hard_reset | status[st_detach] | status[st_reset_close] | mount_reset;

   // ==================================================
   // Menu hide mask
   // ==================================================
   always_comb begin
      menu_mask              = '0;
      menu_mask[mask_fdc]    = fdc_enable;
      menu_mask[mask_slot_a] = rom_a_hide | ocm_enable;
      menu_mask[mask_slot_b] = rom_b_hide | ocm_enable;
      menu_mask[mask_ocm]    = ocm_enable;
      // No SRAM on any cartridge hides save and load
      menu_mask[mask_sram]   = (sram_sizes == '0);
      menu_mask[mask_tape]   = tape_from_adc;
   end

   // Error report
   assign info_req = (error_code != byte_t'(err_none));
   assign info     = error_code;

endmodule

// ==== sd_activity.sv ====
/*
 * SD routing and activity
 * Selects the virtual SD card on image mount, gates the SD pins,
 * picks MISO and lights the user or disk LED on SPI traffic
 */
`timescale 1ns/1ps

module sd_activity #(
   parameter int activity_cycles = msx_cfg_pkg::sd_activity_cycles
) (
   input  logic                     clock_bus,
   input  logic                     reset,
   input  msx_types_pkg::mount_vec_t img_mounted,
   input  msx_types_pkg::img_size_t  img_size,
   input  logic                     spi_sck,
   input  logic                     spi_mosi,
   input  logic                     sd_miso_pin,
   input  logic                     vsd_miso,
   output logic                     sd_cs,
   output logic                     sd_sck,
   output logic                     sd_mosi,
   output logic                     spi_miso,
   output logic                     led_user,
   output logic [1:0]               led_disk
);
   import msx_cfg_pkg::*;

   localparam int cnt_w = $clog2(activity_cycles + 1);
   localparam logic [cnt_w-1:0] act_limit = cnt_w'(activity_cycles);

   logic             vsd_sel;
   logic             mosi_last;
   logic             miso_last;
   logic [cnt_w-1:0] act_cnt;
   logic             sd_act;

   // ==================================================
   // Virtual SD select and pin routing
   // ==================================================
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted[sd_vhd_slot]) begin
         // Empty image means unmount
         vsd_sel <= |img_size;
      end
   end

   assign sd_cs    = vsd_sel;
   assign sd_sck   = spi_sck & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;
   assign spi_miso = vsd_sel ? vsd_miso : sd_miso_pin;

   // ==================================================
   // Bus activity timer
   // ==================================================
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         mosi_last <= 1'b0;
         miso_last <= 1'b0;
         act_cnt   <= act_limit;
      end else begin
         mosi_last <= spi_mosi;
         miso_last <= spi_miso;
         if ((mosi_last ^ spi_mosi) || (miso_last ^ spi_miso)) begin
            act_cnt <= '0;
         end else if (act_cnt < act_limit) begin
            act_cnt <= act_cnt + 1'b1;
         end
      end
   end

   assign sd_act = (act_cnt < act_limit);

   // Virtual card on the user LED, physical card on the disk LED
   assign led_user = vsd_sel & sd_act;
   assign led_disk = {1'b1, ~vsd_sel & sd_act};

endmodule

// ==== cas_control.sv ====
/*
 * Cassette control
 * Load latch, play and rewind for the tape player, tape input
 * choice and the shared DDR3 read port
 */
`timescale 1ns/1ps

module cas_control (
   input  logic                     clock_bus,
   input  logic                     reset,
   input  msx_types_pkg::status_t    status,
   input  logic                     ioctl_download,
   input  msx_types_pkg::io_index_t  ioctl_index,
   input  logic                     tape_motor,
   input  logic                     tape_from_adc,
   input  logic                     cas_bit,
   input  logic                     adc_bit,
   input  logic                     adc_active,
   input  logic                     dl_request,
   input  msx_types_pkg::ddr3_addr_t dl_addr,
   input  logic                     dl_rd,
   input  msx_types_pkg::ddr3_addr_t cas_addr,
   input  logic                     cas_rd,
   output logic                     cas_enable,
   output logic                     cas_play,
   output logic                     cas_rewind,
   output logic                     tape_in_core,
   output msx_types_pkg::ddr3_addr_t ddr3_addr,
   output logic                     ddr3_rd
);
   import msx_cfg_pkg::*;

   logic cas_dl;
   logic cas_dl_last;

   // ==================================================
   // Cassette load latch
   // ==================================================
   assign cas_dl = ioctl_download & (ioctl_index[5:0] == 6'(cas_index));

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         cas_dl_last <= 1'b0;
         cas_enable  <= 1'b0;
      end else begin
         cas_dl_last <= cas_dl;
         // End of a cassette download arms the player
         if (cas_dl_last && !cas_dl) begin
            cas_enable <= 1'b1;
         end
      end
   end

   // Motor line is active low on the MSX side
   assign cas_play   = cas_enable & ~tape_motor;
   assign cas_rewind = status[st_tape_rewind] | cas_dl | reset;

   // Tape input source
   assign tape_in_core = tape_from_adc ? (adc_bit & adc_active) : cas_bit;

   // ==================================================
   // DDR3 read port, loader first
   // ==================================================
   assign ddr3_addr = dl_request ? dl_addr : cas_addr;
   assign ddr3_rd   = dl_request ? dl_rd   : cas_rd;

endmodule

// ==== video_settings.sv ====
/*
 * Video settings
 * Turns the video menu options into scandoubler, scanline, hq2x,
 * aspect, scale and the 216p crop for a full HD output
 */
`timescale 1ns/1ps

module video_settings (
   input  logic                   clock_bus,
   input  logic                   reset,
   input  msx_types_pkg::status_t  status,
   input  logic                   forced_scandoubler,
   input  msx_types_pkg::pix_dim_t hdmi_width,
   input  msx_types_pkg::pix_dim_t hdmi_height,
   output logic                   scandoubler,
   output logic                   hq2x,
   output logic [1:0]             vga_sl,
   output msx_types_pkg::aspect_t  arx,
   output msx_types_pkg::aspect_t  ary,
   output msx_types_pkg::crop_t    crop_size,
   output logic [2:0]             scale_mode
);
   import msx_types_pkg::*;
   import msx_cfg_pkg::*;

   logic [2:0] sd_fx;
   logic [2:0] sl;
   logic [1:0] ar;
   logic       full_hd;

   // ==================================================
   // Scandoubler effects
   // ==================================================
   assign sd_fx = status[st_scandbl_lo +: 3];
   assign sl    = sd_fx - 3'd1;

   assign scandoubler = forced_scandoubler | (sd_fx != 3'd0);
   assign hq2x        = (sd_fx == 3'd1);
   // CRT 25/50/75 map to scanline levels 1 to 3
   assign vga_sl      = (sd_fx != 3'd0) ? sl[1:0] : 2'd0;

   // ==================================================
   // Aspect and scale
   // ==================================================
   assign ar  = status[st_aspect_lo +: 2];
   assign arx = (ar == 2'd0) ? aspect_t'(aspect_orig_x) : aspect_t'(ar - 2'd1);
   assign ary = (ar == 2'd0) ? aspect_t'(aspect_orig_y) : '0;

   assign scale_mode = status[st_scale_lo +: 3];

   // 216p crop only without the scandoubler
   assign full_hd = (hdmi_width == pix_dim_t'(hdmi_full_w)) &&
                    (hdmi_height == pix_dim_t'(hdmi_full_h));

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         crop_size <= '0;
      end else begin
         crop_size <= (full_hd && !scandoubler) ? crop_t'(crop_216) : '0;
      end
   end

endmodule

// ==== msx_glue_top.sv ====
/*
 * MSX glue top
 * Ties reset control, SD routing, cassette control and video
 * settings together on one clock
 */
`timescale 1ns/1ps

module msx_glue_top #(
   parameter int activity_cycles = msx_cfg_pkg::sd_activity_cycles
) (
   input  logic                      clock_bus,
   input  logic                      reset,
   // Menu and loader
   input  msx_types_pkg::status_t     status,
   input  logic                      upload_reset,
   input  msx_types_pkg::mount_vec_t  img_mounted,
   input  msx_types_pkg::img_size_t   img_size,
   input  logic                      fdc_enable,
   input  logic                      ocm_enable,
   input  logic                      rom_a_hide,
   input  logic                      rom_b_hide,
   input  msx_types_pkg::sram_sizes_t sram_sizes,
   input  msx_types_pkg::byte_t       error_code,
   output logic                      hard_reset,
   output logic                      core_reset,
   output msx_types_pkg::menu_mask_t  menu_mask,
   output logic                      info_req,
   output msx_types_pkg::byte_t       info,
   // SD card
   input  logic                      spi_sck,
   input  logic                      spi_mosi,
   input  logic                      sd_miso_pin,
   input  logic                      vsd_miso,
   output logic                      sd_cs,
   output logic                      sd_sck,
   output logic                      sd_mosi,
   output logic                      spi_miso,
   output logic                      led_user,
   output logic [1:0]                led_disk,
   // Cassette and DDR3
   input  logic                      ioctl_download,
   input  msx_types_pkg::io_index_t   ioctl_index,
   input  logic                      tape_motor,
   input  logic                      tape_from_adc,
   input  logic                      cas_bit,
   input  logic                      adc_bit,
   input  logic                      adc_active,
   input  logic                      dl_request,
   input  msx_types_pkg::ddr3_addr_t  dl_addr,
   input  logic                      dl_rd,
   input  msx_types_pkg::ddr3_addr_t  cas_addr,
   input  logic                      cas_rd,
   output logic                      cas_enable,
   output logic                      cas_play,
   output logic                      cas_rewind,
   output logic                      tape_in_core,
   output msx_types_pkg::ddr3_addr_t  ddr3_addr,
   output logic                      ddr3_rd,
   // Video
   input  logic                      forced_scandoubler,
   input  msx_types_pkg::pix_dim_t    hdmi_width,
   input  msx_types_pkg::pix_dim_t    hdmi_height,
   output logic                      scandoubler,
   output logic                      hq2x,
   output logic [1:0]                vga_sl,
   output msx_types_pkg::aspect_t     arx,
   output msx_types_pkg::aspect_t     ary,
   output msx_types_pkg::crop_t       crop_size,
   output logic [2:0]                scale_mode
);

   // System reset only reaches the reset decoder
   core_control u_core_control (
      .clock_bus     (clock_bus),
      .reset         (reset),
      .status        (status),
      .upload_reset  (upload_reset),
      .img_mounted   (img_mounted),
      .fdc_enable    (fdc_enable),
      .ocm_enable    (ocm_enable),
      .rom_a_hide    (rom_a_hide),
      .rom_b_hide    (rom_b_hide),
      .sram_sizes    (sram_sizes),
      .tape_from_adc (tape_from_adc),
      .error_code    (error_code),
      .hard_reset    (hard_reset),
      .core_reset    (core_reset),
      .menu_mask     (menu_mask),
      .info_req      (info_req),
      .info          (info)
   );

   sd_activity #(
      .activity_cycles (activity_cycles)
   ) u_sd_activity (
      .clock_bus   (clock_bus),
      .reset       (core_reset),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .spi_sck     (spi_sck),
      .spi_mosi    (spi_mosi),
      .sd_miso_pin (sd_miso_pin),
      .vsd_miso    (vsd_miso),
      .sd_cs       (sd_cs),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .spi_miso    (spi_miso),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

   cas_control u_cas_control (
      .clock_bus      (clock_bus),
      .reset          (core_reset),
      .status         (status),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .tape_motor     (tape_motor),
      .tape_from_adc  (tape_from_adc),
      .cas_bit        (cas_bit),
      .adc_bit        (adc_bit),
      .adc_active     (adc_active),
      .dl_request     (dl_request),
      .dl_addr        (dl_addr),
      .dl_rd          (dl_rd),
      .cas_addr       (cas_addr),
      .cas_rd         (cas_rd),
      .cas_enable     (cas_enable),
      .cas_play       (cas_play),
      .cas_rewind     (cas_rewind),
      .tape_in_core   (tape_in_core),
      .ddr3_addr      (ddr3_addr),
      .ddr3_rd        (ddr3_rd)
   );

   video_settings u_video_settings (
      .clock_bus          (clock_bus),
      .reset              (core_reset),
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .scandoubler        (scandoubler),
      .hq2x               (hq2x),
      .vga_sl             (vga_sl),
      .arx                (arx),
      .ary                (ary),
      .crop_size          (crop_size),
      .scale_mode         (scale_mode)
   );

endmodule

// ==== msx_glue_checker.sv ====
/*
 * MSX glue checker
 * Watches the DUT outputs, compares them per test with expected
 * values and keeps the pass and fail counts
 */
`timescale 1ns/1ps

module msx_glue_checker (
   input logic                      hard_reset,
   input logic                      core_reset,
   input msx_types_pkg::menu_mask_t  menu_mask,
   input logic                      info_req,
   input msx_types_pkg::byte_t       info,
   input logic                      sd_cs,
   input logic                      sd_sck,
   input logic                      sd_mosi,
   input logic                      spi_miso,
   input logic                      led_user,
   input logic [1:0]                led_disk,
   input logic                      cas_enable,
   input logic                      cas_play,
   input logic                      cas_rewind,
   input logic                      tape_in_core,
   input msx_types_pkg::ddr3_addr_t  ddr3_addr,
   input logic                      ddr3_rd,
   input logic                      scandoubler,
   input logic                      hq2x,
   input logic [1:0]                vga_sl,
   input msx_types_pkg::aspect_t     arx,
   input msx_types_pkg::aspect_t     ary,
   input msx_types_pkg::crop_t       crop_size,
   input logic [2:0]                scale_mode
);
   int pass_count = 0;
   int fail_count = 0;

   // Output group picked by the test row
   function automatic logic [63:0] observe(input int sel);
      case (sel)
         0:       observe = 64'({hard_reset, core_reset});
         1:       observe = 64'(menu_mask);
         2:       observe = 64'({info_req, info});
         3:       observe = 64'({scandoubler, hq2x, vga_sl, arx, ary, scale_mode});
         4:       observe = 64'(crop_size);
         5:       observe = 64'({sd_cs, sd_sck, sd_mosi, spi_miso, led_user, led_disk});
         default: observe = 64'({cas_enable, cas_play, cas_rewind, tape_in_core,
                                 ddr3_rd, ddr3_addr});
      endcase
   endfunction

   task automatic check(input string name, input int sel, input logic [63:0] exp);
      logic [63:0] act;
      act = observe(sel);
      if (act === exp) begin
         pass_count++;
         $display("ok       %s", name);
      end else begin
         fail_count++;
         $display("mismatch %s expected %h actual %h", name, exp, act);
      end
   endtask

   task automatic report_timeout(input string name);
      fail_count++;
      $display("%s timed out waiting for the expected outputs", name);
   endtask

   task automatic report_counts();
      $display("tests %0d passed %0d failed %0d",
               pass_count + fail_count, pass_count, fail_count);
   endtask

endmodule

// ==== tb_msx_glue.sv ====
/*
 * MSX glue testbench
 * Applies a table of stimulus rows to the glue top and lets the
 * checker compare each row's outputs
 */
`timescale 1ns/1ps

module tb_msx_glue;
   import msx_types_pkg::*;
   import msx_cfg_pkg::*;

   // Single-bit input masks for the table
   localparam logic [19:0] fl_upload   = 20'h00001;
   localparam logic [19:0] fl_fdc      = 20'h00002;
   localparam logic [19:0] fl_ocm      = 20'h00004;
   localparam logic [19:0] fl_rom_a    = 20'h00008;
   localparam logic [19:0] fl_rom_b    = 20'h00010;
   localparam logic [19:0] fl_adc      = 20'h00020;
   localparam logic [19:0] fl_mount    = 20'h00040;
   localparam logic [19:0] fl_dl       = 20'h00080;
   localparam logic [19:0] fl_motor    = 20'h00100;
   localparam logic [19:0] fl_cas_bit  = 20'h00200;
   localparam logic [19:0] fl_adc_bit  = 20'h00400;
   localparam logic [19:0] fl_adc_act  = 20'h00800;
   localparam logic [19:0] fl_dl_req   = 20'h01000;
   localparam logic [19:0] fl_dl_rd    = 20'h02000;
   localparam logic [19:0] fl_cas_rd   = 20'h04000;
   localparam logic [19:0] fl_forced   = 20'h08000;
   localparam logic [19:0] fl_mosi     = 20'h10000;
   localparam logic [19:0] fl_miso_pin = 20'h20000;
   localparam logic [19:0] fl_vsd_miso = 20'h40000;
   localparam logic [23:0] full_hd = {12'd1920, 12'd1080};
   localparam logic [27:0] dl_base = 28'h0123456;
   localparam logic [27:0] cas_base = 28'h0abcdef;

   logic clock_bus, reset, upload_reset, fdc_enable, ocm_enable, rom_a_hide, rom_b_hide;
   logic hard_reset, core_reset, info_req, spi_sck, spi_mosi, sd_miso_pin, vsd_miso;
   logic sd_cs, sd_sck, sd_mosi, spi_miso, led_user, ioctl_download, tape_motor;
   logic tape_from_adc, cas_bit, adc_bit, adc_active, dl_request, dl_rd, cas_rd;
   logic cas_enable, cas_play, cas_rewind, tape_in_core, ddr3_rd, forced_scandoubler;
   logic scandoubler, hq2x;
   logic [1:0] led_disk, vga_sl;
   logic [2:0] scale_mode;
   status_t status;
   mount_vec_t img_mounted;
   img_size_t img_size;
   sram_sizes_t sram_sizes;
   byte_t error_code, info;
   menu_mask_t menu_mask;
   io_index_t ioctl_index;
   ddr3_addr_t dl_addr, cas_addr, ddr3_addr;
   pix_dim_t hdmi_width, hdmi_height;
   aspect_t arx, ary;
   crop_t crop_size;

   // Stimulus table with one entry per row in each queue
   string names[$];
   status_t st_q[$];
   logic [19:0] fl_q[$];
   logic [63:0] data_q[$], exp_q[$];
   byte_t err_q[$];
   logic [23:0] hd_q[$];
   int sel_q[$], lat_q[$];

   msx_glue_top #(.activity_cycles(64)) u_dut (.*);
   msx_glue_checker u_chk (.*);

   initial begin
      clock_bus = 1'b0;
      forever #4 clock_bus = ~clock_bus;
   end

   // Latency 0 samples in the same cycle and -1 polls with a timeout
   task automatic add_row(input string n, input status_t st, input logic [19:0] fl,
                          input logic [63:0] data, input byte_t err, input logic [23:0] hd,
                          input int sel, input logic [63:0] exp, input int lat);
      names.push_back(n);
      st_q.push_back(st);
      fl_q.push_back(fl);
      data_q.push_back(data);
      err_q.push_back(err);
      hd_q.push_back(hd);
      sel_q.push_back(sel);
      exp_q.push_back(exp);
      lat_q.push_back(lat);
   endtask

   task automatic drive(input status_t st, input logic [19:0] fl, input logic [63:0] data,
                        input byte_t err, input logic [23:0] hd);
      status = st;
      {vsd_miso, sd_miso_pin} = fl[18:17];
      {spi_mosi, forced_scandoubler, cas_rd, dl_rd, dl_request, adc_active, adc_bit,
       cas_bit, tape_motor, ioctl_download} = fl[16:7];
      img_mounted = {1'b0, fl[6], 4'b0};
      {tape_from_adc, rom_b_hide, rom_a_hide, ocm_enable, fdc_enable, upload_reset} = fl[5:0];
      img_size = data;
      sram_sizes = data;
      error_code = err;
      {hdmi_width, hdmi_height} = hd;
   endtask

   task automatic run_row(input int i);
      bit done;
      @(posedge clock_bus);
      #1 drive(st_q[i], fl_q[i], data_q[i], err_q[i], hd_q[i]);
      if (lat_q[i] >= 0) begin
         repeat (lat_q[i]) @(posedge clock_bus);
         #6 u_chk.check(names[i], sel_q[i], exp_q[i]);
      end else begin
         done = 0;
         for (int n = 0; n < 100 && !done; n++) begin
            @(posedge clock_bus);
            #6 done = (u_chk.observe(sel_q[i]) === exp_q[i]);
         end
         if (done) u_chk.check(names[i], sel_q[i], exp_q[i]);
         else u_chk.report_timeout(names[i]);
      end
   endtask

   // Hard and core reset from the OR rules
   function automatic logic [63:0] reset_model(input status_t st, input logic [19:0] fl);
      logic hard;
      hard = st[st_reset] | fl[0];
      reset_model = {hard, hard | st[st_detach] | st[st_reset_close] |
                     (st[st_mount_reset] & fl[6] & fl[1])};
   endfunction

   initial begin
      status_t rs;
      logic [19:0] rf;
      void'($urandom(32'hbb8e_4ffb));
      reset = 1'b1;
      spi_sck = 1'b1;
      ioctl_index = 16'd5;
      dl_addr = dl_base;
      cas_addr = cas_base;
      drive('0, '0, '0, '0, '0);
      add_row("rst_none", 64'h0, 0, 1, 0, 0, 0, 64'h0, 0);
      add_row("rst_status_bit", 64'h1, 0, 1, 0, 0, 0, 64'h3, 0);
      add_row("rst_detach", 64'h400, 0, 1, 0, 0, 0, 64'h1, 0);
      add_row("rst_close", 64'h20_0000, 0, 1, 0, 0, 0, 64'h1, 0);
      add_row("rst_upload", 64'h0, fl_upload, 1, 0, 0, 0, 64'h3, 0);
      add_row("rst_mount_fdc", 64'h1000, fl_mount | fl_fdc, 0, 0, 0, 0, 64'h1, 0);
      add_row("rst_mount_no_fdc", 64'h1000, fl_mount, 0, 0, 0, 0, 64'h0, 0);
      add_row("mask_fdc_tape", 0, fl_fdc | fl_adc, 64'h2_0000, 0, 0, 1, 64'h81, 0);
      add_row("mask_rom_a", 0, fl_rom_a, 64'h2_0000, 0, 0, 1, 64'h02, 0);
      add_row("mask_rom_b", 0, fl_rom_b, 64'h2_0000, 0, 0, 1, 64'h04, 0);
      add_row("mask_ocm", 0, fl_ocm, 64'h2_0000, 0, 0, 1, 64'h0e, 0);
      add_row("mask_sram_zero", 0, 0, 64'h0, 0, 0, 1, 64'h40, 0);
      add_row("info_none", 0, 0, 1, 8'h00, 0, 2, 64'h000, 0);
      add_row("info_error", 0, 0, 1, 8'h5a, 0, 2, 64'h15a, 0);
      add_row("vid_default", 0, 0, 1, 0, 0, 3, {4'b0000, 12'd4, 12'd3, 3'd0}, 0);
      add_row("vid_hq2x_ar1", 64'h0a, 0, 1, 0, 0, 3, {4'b1100, 12'd0, 12'd0, 3'd0}, 0);
      add_row("vid_sl3_ar3", 64'h166, 0, 1, 0, 0, 3, {4'b1011, 12'd2, 12'd0, 3'd5}, 0);
      add_row("vid_sl2_ar2", 64'h1c, 0, 1, 0, 0, 3, {4'b1010, 12'd1, 12'd0, 3'd0}, 0);
      add_row("vid_forced", 0, fl_forced, 1, 0, 0, 3, {4'b1000, 12'd4, 12'd3, 3'd0}, 0);
      add_row("crop_full_hd", 0, 0, 1, 0, full_hd, 4, 64'd216, 1);
      add_row("crop_scandbl", 64'h8, 0, 1, 0, full_hd, 4, 64'd0, 1);
      add_row("crop_720p", 0, 0, 1, 0, {12'd1280, 12'd720}, 4, 64'd0, 1);
      add_row("cas_download", 0, fl_dl | fl_motor, 1, 0, 0, 6, {5'b00100, cas_base}, 0);
      add_row("cas_dl_end", 0, fl_motor, 1, 0, 0, 6, {5'b10000, cas_base}, 1);
      add_row("cas_play", 0, fl_cas_bit, 1, 0, 0, 6, {5'b11010, cas_base}, 0);
      add_row("cas_adc_idle", 0, fl_adc | fl_adc_bit | fl_cas_bit, 1, 0, 0, 6,
              {5'b11000, cas_base}, 0);
      add_row("cas_adc_active", 0, fl_adc | fl_adc_bit | fl_adc_act, 1, 0, 0, 6,
              {5'b11010, cas_base}, 0);
      add_row("cas_ddr_loader", 0, fl_dl_req | fl_dl_rd, 1, 0, 0, 6, {5'b11001, dl_base}, 0);
      add_row("cas_ddr_player", 0, fl_cas_rd, 1, 0, 0, 6, {5'b11001, cas_base}, 0);
      add_row("cas_rewind_bit", 64'h200, 0, 1, 0, 0, 6, {5'b11100, cas_base}, 0);
      add_row("sd_after_reset", 0, 0, 1, 0, 0, 5, 64'b0100010, 0);
      add_row("sd_mount_vsd", 0, fl_mount, 64'h1000, 0, 0, 5, 64'b1000010, 1);
      add_row("sd_mosi_toggle", 0, fl_mosi, 64'h1000, 0, 0, 5, 64'b1000110, 1);
      add_row("sd_led_dark", 0, fl_mosi, 64'h1000, 0, 0, 5, 64'b1000010, -1);
      add_row("sd_unmount", 0, fl_mosi | fl_mount, 64'h0, 0, 0, 5, 64'b0110010, 1);
      add_row("sd_disk_activity", 0, 0, 64'h0, 0, 0, 5, 64'b0100011, 1);
      add_row("sd_miso_pin", 0, fl_miso_pin, 64'h0, 0, 0, 5, 64'b0101011, 1);
      add_row("sd_miso_vsd", 0, fl_mount | fl_vsd_miso, 64'h1000, 0, 0, 5,
              64'b1001110, 1);
      for (int r = 0; r < 16; r++) begin
         rs = {$urandom, $urandom};
         rf = 20'($urandom) & (fl_upload | fl_mount | fl_fdc);
         add_row($sformatf("rst_random_%0d", r), rs, rf, 0, 0, 0, 0, reset_model(rs, rf), 0);
      end
      repeat (8) @(posedge clock_bus);
      #1 reset = 1'b0;
      foreach (names[i]) run_row(i);
      u_chk.report_counts();
      if (u_chk.fail_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   // Watchdog on the whole run
   initial begin
      for (int c = 0; c < 20000; c++) @(posedge clock_bus);
      $display("run did not finish within its cycle budget");
      $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== msx_glue.f ====
msx_types_pkg.sv
msx_cfg_pkg.sv
core_control.sv
sd_activity.sv
cas_control.sv
video_settings.sv
msx_glue_top.sv
msx_glue_checker.sv
tb_msx_glue.sv
